// ==== src/uart_pkg.sv ====
package uart_pkg;

    // 00 and 11 both mean no parity bit
    typedef enum logic [1:0] {
        PAR_NONE     = 2'b00,
        PAR_EVEN     = 2'b01,
        PAR_ODD      = 2'b10,
        PAR_NONE_ALT = 2'b11
    } parity_t;

    typedef struct packed {
        parity_t     parity;
        logic        stop_sel;     // 0: one stop bit, 1: two
        logic [23:0] baudcontrol;  // clock cycles per bit minus one
    } uart_cfg_t;

    // trmt is the msb of TXSTAT, wrdone the lsb
    typedef struct packed {
        logic       trmt;          // tx buffer empty
        logic       txbf;          // tx buffer full
        logic [4:0] buffer_count;
        logic       wrdone;        // high during the last stop bit
    } tx_status_t;

    // frame_err in bit 9, parity_err in bit 8, data below
    typedef struct packed {
        logic       frame_err;
        logic       parity_err;
        logic [7:0] data;
    } rx_frame_t;

    typedef struct packed {
        logic       rx_empty;
        logic       rx_full;
        logic [4:0] rx_count;
    } rx_status_t;

    typedef logic [2:0] addr_t;

    localparam addr_t ADDR_CON    = 3'd0;
    localparam addr_t ADDR_DIN    = 3'd1;
    localparam addr_t ADDR_BAUD   = 3'd2;
    localparam addr_t ADDR_TXSTAT = 3'd3;
    localparam addr_t ADDR_RXDATA = 3'd4;
    localparam addr_t ADDR_RXSTAT = 3'd5;

endpackage

// ==== src/uart_fifo.sv ====
`timescale 1ns/10ps

module uart_fifo #(
    parameter int  FIFO_DEPTH = 16,
    parameter type payload_t  = logic [7:0]
) (
    input  logic       clk,
    input  logic       nrst,
    input  logic       push,
    input  logic       pop,
    input  payload_t   din,
    output payload_t   dout,
    output logic [4:0] count,
    output logic       empty,
    output logic       full
);

    localparam int AW = $clog2(FIFO_DEPTH);

    payload_t       mem [FIFO_DEPTH];
    logic [AW-1:0]  wr_ptr;
    logic [AW-1:0]  rd_ptr;
    logic           do_push;   // push that is actually taken
    logic           do_pop;

    // pointers wrap at FIFO_DEPTH, which need not be a power of two
    function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] p);
        return (p == AW'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign empty   = (count == 5'd0);
    assign full    = (count == 5'(FIFO_DEPTH));
    assign do_push = push & ~full;    // push on a full buffer is lost
    assign do_pop  = pop & ~empty;    // pop on empty does nothing
    assign dout    = mem[rd_ptr];     // head is always visible

    always_ff @(posedge clk) begin
        if (do_push) mem[wr_ptr] <= din;
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= 5'd0;
        end else begin
            if (do_push) wr_ptr <= next_ptr(wr_ptr);
            if (do_pop) rd_ptr <= next_ptr(rd_ptr);
            case ({do_push, do_pop})
                2'b10:   count <= count + 5'd1;
                2'b01:   count <= count - 5'd1;
                default: count <= count;   // none, or both at once
            endcase
        end
    end

    a_count_max: assert property (@(posedge clk) disable iff (!nrst)
        count <= 5'(FIFO_DEPTH));
    a_not_both: assert property (@(posedge clk) disable iff (!nrst)
        !(empty && full));

endmodule

// ==== src/uart_encoder.sv ====
`timescale 1ns/10ps

module uart_encoder #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic                 clk,
    input  logic                 nrst,
    input  uart_pkg::uart_cfg_t  cfg,
    input  logic [7:0]           tx_data,
    input  logic                 en,
    output logic                 tx,
    output uart_pkg::tx_status_t tx_status
);

    import uart_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE, ST_START, ST_DATA, ST_PARITY, ST_STOP
    } state_t;

    state_t      state;
    logic [23:0] baud_cnt;     // cycles into the current bit
    logic [2:0]  bit_idx;      // data bit on the line
    logic [7:0]  shift;        // lsb is driven out
    logic        parity_bit;
    logic        stop_flag;    // first stop bit done
    logic        en_q;
    logic        bit_end;
    logic        par_on;
    logic        wrdone;
    logic        buf_push;
    logic        buf_pop;
    logic        buf_empty;
    logic        buf_full;
    logic [7:0]  buf_dout;
    logic [4:0]  buf_count;

    assign bit_end  = (baud_cnt == cfg.baudcontrol);
    assign par_on   = (cfg.parity == PAR_EVEN) || (cfg.parity == PAR_ODD);
    assign buf_push = en_q & ~en & ~buf_full;   // one cycle after en falls
    // head leaves the buffer once its last data bit is out
    assign buf_pop  = (state == ST_DATA) && (bit_idx == 3'd7) && bit_end;

    uart_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .payload_t  (logic [7:0])
    ) tx_fifo_i (
        .clk   (clk),
        .nrst  (nrst),
        .push  (buf_push),
        .pop   (buf_pop),
        .din   (tx_data),
        .dout  (buf_dout),
        .count (buf_count),
        .empty (buf_empty),
        .full  (buf_full)
    );

    function automatic logic calc_parity(input logic [7:0] b, input parity_t p);
        return (p == PAR_ODD) ? ~(^b) : ^b;
    endfunction

    always_ff @(posedge clk) begin
        if (!nrst) en_q <= 1'b0;
        else en_q <= en;
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            state      <= ST_IDLE;
            baud_cnt   <= 24'd0;
            bit_idx    <= 3'd0;
            shift      <= 8'd0;
            parity_bit <= 1'b0;
            stop_flag  <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    baud_cnt <= 24'd0;
                    bit_idx  <= 3'd0;
                    if (!buf_empty) begin     // load head and start
                        shift      <= buf_dout;
                        parity_bit <= calc_parity(buf_dout, cfg.parity);
                        stop_flag  <= 1'b0;
                        state      <= ST_START;
                    end
                end
                ST_START: begin
                    if (bit_end) begin
                        baud_cnt <= 24'd0;
                        state    <= ST_DATA;
                    end else baud_cnt <= baud_cnt + 24'd1;
                end
                ST_DATA: begin
                    if (bit_end) begin
                        baud_cnt <= 24'd0;
                        shift    <= {1'b0, shift[7:1]};
                        bit_idx  <= bit_idx + 3'd1;   // wraps to 0 after bit 7
                        if (bit_idx == 3'd7) state <= par_on ? ST_PARITY : ST_STOP;
                    end else baud_cnt <= baud_cnt + 24'd1;
                end
                ST_PARITY: begin
                    if (bit_end) begin
                        baud_cnt <= 24'd0;
                        state    <= ST_STOP;
                    end else baud_cnt <= baud_cnt + 24'd1;
                end
                ST_STOP: begin
                    if (bit_end) begin
                        baud_cnt <= 24'd0;
                        if (cfg.stop_sel && !stop_flag) begin
                            stop_flag <= 1'b1;          // one more stop bit
                        end else if (!buf_empty) begin  // back to back frame
                            shift      <= buf_dout;
                            parity_bit <= calc_parity(buf_dout, cfg.parity);
                            stop_flag  <= 1'b0;
                            state      <= ST_START;
                        end else state <= ST_IDLE;
                    end else baud_cnt <= baud_cnt + 24'd1;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_comb begin
        tx     = 1'b1;   // idle and stop level
        wrdone = 1'b0;
        case (state)
            ST_START:  tx = 1'b0;
            ST_DATA:   tx = shift[0];
            ST_PARITY: tx = parity_bit;
            ST_STOP:   wrdone = !cfg.stop_sel || stop_flag;
            default:   tx = 1'b1;
        endcase
    end

    assign tx_status = '{trmt: buf_empty, txbf: buf_full,
                         buffer_count: buf_count, wrdone: wrdone};

    // line rests high whenever the FSM is idle
    a_idle_high: assert property (@(posedge clk) disable iff (!nrst)
        (state == ST_IDLE) |-> tx);
    a_push_taken: assert property (@(posedge clk) disable iff (!nrst)
        (buf_push && !buf_pop) |=> (buf_count == $past(buf_count) + 5'd1));

endmodule

// ==== src/uart_decoder.sv ====
`timescale 1ns/10ps

module uart_decoder (
    input  logic                clk,
    input  logic                nrst,
    input  uart_pkg::uart_cfg_t cfg,
    input  logic                rx,
    input  logic                full,
    output logic                push,
    output uart_pkg::rx_frame_t frame
);

    import uart_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE, ST_START, ST_DATA, ST_PARITY, ST_STOP
    } state_t;

    state_t      state;
    logic        rx_meta;       // first sync flop
    logic        rx_sync;       // usable line level
    logic        rx_prev;       // for edge detection
    logic [23:0] cnt;
    logic [2:0]  bit_idx;
    logic [7:0]  shift;         // bits enter at the msb
    logic        par_err;
    logic        stop_bad;      // a stop bit sampled low
    logic        stop_flag;     // first of two stop bits seen
    logic        start_fall;
    logic        at_sample;
    logic        par_on;

    assign start_fall = rx_prev & ~rx_sync;
    assign at_sample  = (cnt == cfg.baudcontrol);
    assign par_on     = (cfg.parity == PAR_EVEN) || (cfg.parity == PAR_ODD);

    always_ff @(posedge clk) begin
        if (!nrst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            state     <= ST_IDLE;
            cnt       <= 24'd0;
            bit_idx   <= 3'd0;
            shift     <= 8'd0;
            par_err   <= 1'b0;
            stop_bad  <= 1'b0;
            stop_flag <= 1'b0;
            push      <= 1'b0;
        end else begin
            push <= 1'b0;
            case (state)
                ST_IDLE: begin
                    cnt       <= 24'd0;
                    bit_idx   <= 3'd0;
                    par_err   <= 1'b0;
                    stop_bad  <= 1'b0;
                    stop_flag <= 1'b0;
                    if (start_fall) state <= ST_START;
                end
                ST_START: begin
                    if (cnt == (cfg.baudcontrol >> 1)) begin   // mid start bit
                        cnt   <= 24'd0;
                        state <= rx_sync ? ST_IDLE : ST_DATA;  // glitch, back off
                    end else cnt <= cnt + 24'd1;
                end
                ST_DATA: begin
                    if (at_sample) begin
                        cnt     <= 24'd0;
                        shift   <= {rx_sync, shift[7:1]};   // lsb first on the line
                        bit_idx <= bit_idx + 3'd1;
                        if (bit_idx == 3'd7) state <= par_on ? ST_PARITY : ST_STOP;
                    end else cnt <= cnt + 24'd1;
                end
                ST_PARITY: begin
                    if (at_sample) begin
                        cnt     <= 24'd0;
                        // even: bit must equal xor of data, odd: its inverse
                        par_err <= rx_sync ^ (^shift) ^ (cfg.parity == PAR_ODD);
                        state   <= ST_STOP;
                    end else cnt <= cnt + 24'd1;
                end
                ST_STOP: begin
                    if (at_sample) begin
                        cnt <= 24'd0;
                        if (cfg.stop_sel && !stop_flag) begin
                            stop_flag <= 1'b1;
                            stop_bad  <= ~rx_sync;
                        end else begin
                            push  <= ~full;   // no room, frame is dropped
                            state <= ST_IDLE;
                        end
                    end else cnt <= cnt + 24'd1;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // payload captured with the push
    always_ff @(posedge clk) begin
        if (state == ST_STOP && at_sample) begin
            frame <= '{frame_err: stop_bad | ~rx_sync, parity_err: par_err, data: shift};
        end
    end

    // push is decided a cycle ahead, full must not have risen since
    a_no_push_full: assert property (@(posedge clk) disable iff (!nrst)
        push |-> !full);

endmodule

// ==== src/uart_regs.sv ====
`timescale 1ns/10ps

module uart_regs (
    input  logic                 clk,
    input  logic                 nrst,
    input  logic                 wr,
    input  logic                 rd,
    input  uart_pkg::addr_t      addr,
    input  logic [31:0]          wdata,
    output logic [31:0]          rdata,
    output uart_pkg::uart_cfg_t  cfg,
    output logic [7:0]           tx_data,
    output logic                 en,
    input  uart_pkg::tx_status_t tx_status,
    output logic                 rx_pop,
    input  uart_pkg::rx_frame_t  rx_frame,
    input  uart_pkg::rx_status_t rx_status
);

    import uart_pkg::*;

    // pop together with the read, frame is latched into rdata at the same edge
    assign rx_pop = rd && (addr == ADDR_RXDATA) && !rx_status.rx_empty;

    always_ff @(posedge clk) begin
        if (!nrst) begin
            cfg <= '0;      // no parity, one stop bit, divisor 0
            en  <= 1'b0;
        end else if (wr) begin
            case (addr)
                ADDR_CON: begin
                    en           <= wdata[0];
                    cfg.parity   <= parity_t'(wdata[2:1]);
                    cfg.stop_sel <= wdata[3];
                end
                ADDR_BAUD: cfg.baudcontrol <= wdata[23:0];
                default:   en <= en;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr && addr == ADDR_DIN) tx_data <= wdata[7:0];
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            rdata <= 32'd0;
        end else if (rd) begin
            case (addr)
                ADDR_CON:    rdata <= {28'd0, cfg.stop_sel, cfg.parity, en};
                ADDR_DIN:    rdata <= {24'd0, tx_data};
                ADDR_BAUD:   rdata <= {8'd0, cfg.baudcontrol};
                ADDR_TXSTAT: rdata <= {24'd0, tx_status};
                ADDR_RXDATA: rdata <= rx_status.rx_empty ? 32'd0 : {22'd0, rx_frame};
                ADDR_RXSTAT: rdata <= {25'd0, rx_status};
                default:     rdata <= 32'd0;   // unmapped
            endcase
        end
    end

endmodule

// ==== src/uart_top.sv ====
`timescale 1ns/10ps

module uart_top #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic            clk,
    input  logic            nrst,
    input  logic            wr,
    input  logic            rd,
    input  uart_pkg::addr_t addr,
    input  logic [31:0]     wdata,
    output logic [31:0]     rdata,
    output logic            tx,
    input  logic            rx
);

    import uart_pkg::*;

    uart_cfg_t  cfg;
    tx_status_t tx_status;
    rx_status_t rx_status;
    rx_frame_t  dec_frame;     // decoder to fifo
    rx_frame_t  rx_frame;      // fifo head to registers
    logic [7:0] tx_data;
    logic       en;
    logic       dec_push;
    logic       rx_pop;
    logic [4:0] rx_count;
    logic       rx_empty;
    logic       rx_full;

    assign rx_status = '{rx_empty: rx_empty, rx_full: rx_full, rx_count: rx_count};

    uart_regs regs_i (
        .clk       (clk),
        .nrst      (nrst),
        .wr        (wr),
        .rd        (rd),
        .addr      (addr),
        .wdata     (wdata),
        .rdata     (rdata),
        .cfg       (cfg),
        .tx_data   (tx_data),
        .en        (en),
        .tx_status (tx_status),
        .rx_pop    (rx_pop),
        .rx_frame  (rx_frame),
        .rx_status (rx_status)
    );

    uart_encoder #(.FIFO_DEPTH(FIFO_DEPTH)) encoder_i (
        .clk       (clk),
        .nrst      (nrst),
        .cfg       (cfg),
        .tx_data   (tx_data),
        .en        (en),
        .tx        (tx),
        .tx_status (tx_status)
    );

    uart_decoder decoder_i (
        .clk   (clk),
        .nrst  (nrst),
        .cfg   (cfg),
        .rx    (rx),
        .full  (rx_full),
        .push  (dec_push),
        .frame (dec_frame)
    );

    uart_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .payload_t  (rx_frame_t)
    ) rx_fifo_i (
        .clk   (clk),
        .nrst  (nrst),
        .push  (dec_push),
        .pop   (rx_pop),
        .din   (dec_frame),
        .dout  (rx_frame),
        .count (rx_count),
        .empty (rx_empty),
        .full  (rx_full)
    );

endmodule

// ==== bench/uart_tb.sv ====
`timescale 1ns/10ps

module uart_tb;

    import uart_pkg::*;

    localparam int BIT_CYC    = 8;              // baudcontrol 7
    localparam int BIT_NS     = BIT_CYC * 10;
    localparam int POLL_LIMIT = 4000;           // RXSTAT reads before giving up
    // about 60 frames of up to 12 bits at 8 cycles come to some 6000 cycles,
    // the rest is room for bus polling and idle gaps
    localparam int TIMEOUT_CYCLES = 20000;

    logic        clk = 1'b0;
    logic        nrst;
    logic        wr;
    logic        rd;
    addr_t       addr;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic        tx;
    logic        rx;
    logic        drv_rx;        // line level from the frame driver
    logic        loopback;      // 1: rx follows tx

    int          errors;
    int          tests_run;
    int          tests_failed;
    int          cycle_cnt;
    rx_frame_t   got_q[$];      // frames popped from RXDATA
    logic [7:0]  exp_q[$];      // bytes expected back, in order

    assign rx = loopback ? tx : drv_rx;

    uart_top #(.FIFO_DEPTH(16)) uart_top_i (
        .clk   (clk),
        .nrst  (nrst),
        .wr    (wr),
        .rd    (rd),
        .addr  (addr),
        .wdata (wdata),
        .rdata (rdata),
        .tx    (tx),
        .rx    (rx)
    );

    always #5 clk = ~clk;

    // watchdog
    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: run stopped after %0d cycles", cycle_cnt);
        $display("RESULT: FAIL");
        $finish;
    end

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("ERR %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
        errors++;
    endtask

    task automatic report_problem(input string what);
        $display("problem at %0t: %s", $time, what);
        errors++;
    endtask

    task automatic finish_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - err_before);
        end
    endtask

    // both tasks are entered at a falling edge and leave at the next one
    task automatic bus_write(input addr_t a, input logic [31:0] d);
        addr  = a;
        wdata = d;
        wr    = 1'b1;
        @(negedge clk);
        wr    = 1'b0;
    endtask

    task automatic bus_read(input addr_t a, output logic [31:0] d);
        addr = a;
        rd   = 1'b1;
        @(negedge clk);
        rd   = 1'b0;
        d    = rdata;     // registered at the rising edge in between
    endtask

    function automatic logic [31:0] con_word(input logic [1:0] par, input logic stop_sel,
                                             input logic en_bit);
        return {28'd0, stop_sel, par, en_bit};
    endfunction

    // parity bit from a count of the ones in the byte
    function automatic logic expected_parity(input logic [7:0] b, input logic [1:0] par);
        int ones;
        int i;
        ones = 0;
        for (i = 0; i < 8; i++) ones += int'(b[i]);
        if (par == PAR_ODD) expected_parity = ((ones % 2) == 0);
        else expected_parity = ((ones % 2) == 1);
    endfunction

    function automatic logic has_parity(input logic [1:0] par);
        return (par == PAR_EVEN) || (par == PAR_ODD);
    endfunction

    task automatic send_byte(input logic [7:0] b, input logic [1:0] par,
                             input logic stop_sel);
        bus_write(ADDR_DIN, {24'd0, b});
        bus_write(ADDR_CON, con_word(par, stop_sel, 1'b1));
        bus_write(ADDR_CON, con_word(par, stop_sel, 1'b0));   // falling en queues the byte
    endtask

    // rebuilds one frame from tx, sampling at mid-bit after the start edge
    task automatic monitor_frame(input logic [1:0] par, input logic stop_sel,
                                 output logic [7:0] data, output time t_start);
        logic [7:0] bits;
        int         n;
        bits = 8'd0;
        @(negedge tx);
        t_start = $time;
        repeat (BIT_CYC / 2) @(negedge clk);
        if (tx !== 1'b0) report_problem("start bit not low at mid-bit");
        for (n = 0; n < 8; n++) begin
            repeat (BIT_CYC) @(negedge clk);
            bits = {tx, bits[7:1]};         // lsb arrives first
        end
        if (has_parity(par)) begin
            repeat (BIT_CYC) @(negedge clk);
            if (tx !== expected_parity(bits, par))
                report_mismatch("tx parity bit", 32'(tx), 32'(expected_parity(bits, par)));
        end
        for (n = 0; n < (stop_sel ? 2 : 1); n++) begin
            repeat (BIT_CYC) @(negedge clk);
            if (tx !== 1'b1) report_mismatch("tx stop bit", 32'(tx), 32'd1);
        end
        data = bits;
    endtask

    // drives one frame on rx with loopback off, faults on request
    task automatic drive_frame(input logic [7:0] b, input logic [1:0] par,
                               input logic flip_par, input logic low_stop);
        logic [7:0] shift;
        int         n;
        shift  = b;
        drv_rx = 1'b0;                               // start bit
        repeat (BIT_CYC) @(negedge clk);
        for (n = 0; n < 8; n++) begin
            drv_rx = shift[0];
            shift  = shift >> 1;
            repeat (BIT_CYC) @(negedge clk);
        end
        if (has_parity(par)) begin
            drv_rx = expected_parity(b, par) ^ flip_par;
            repeat (BIT_CYC) @(negedge clk);
        end
        drv_rx = ~low_stop;
        repeat (BIT_CYC) @(negedge clk);
        drv_rx = 1'b1;
        repeat (2 * BIT_CYC) @(negedge clk);         // idle gap
    endtask

    // pops n frames into got_q, polling RXSTAT
    task automatic collect_frames(input int n);
        logic [31:0] d;
        rx_status_t  st;
        int          polls;
        got_q.delete();
        polls = 0;
        while (got_q.size() < n && polls < POLL_LIMIT) begin
            bus_read(ADDR_RXSTAT, d);
            st = rx_status_t'(d[6:0]);
            if (!st.rx_empty) begin
                bus_read(ADDR_RXDATA, d);
                got_q.push_back(rx_frame_t'(d[9:0]));
            end
            polls++;
        end
    endtask

    // got_q against exp_q, no error flags allowed
    task automatic check_frames();
        rx_frame_t exp_f;
        int        i;
        if (got_q.size() != exp_q.size())
            report_problem($sformatf("received %0d frames, expected %0d",
                                     got_q.size(), exp_q.size()));
        for (i = 0; i < got_q.size() && i < exp_q.size(); i++) begin
            exp_f = '{frame_err: 1'b0, parity_err: 1'b0, data: exp_q[i]};
            if (got_q[i] !== exp_f) report_mismatch("rxdata", 32'(got_q[i]), 32'(exp_f));
        end
    endtask

    task automatic reset_state();
        int          err0;
        logic [31:0] d;
        tx_status_t  exp_ts;
        rx_status_t  exp_rs;
        err0   = errors;
        exp_ts = '{trmt: 1'b1, txbf: 1'b0, buffer_count: 5'd0, wrdone: 1'b0};
        exp_rs = '{rx_empty: 1'b1, rx_full: 1'b0, rx_count: 5'd0};
        if (tx !== 1'b1) report_mismatch("tx", 32'(tx), 32'd1);
        bus_read(ADDR_TXSTAT, d);
        if (d !== 32'(exp_ts)) report_mismatch("txstat", d, 32'(exp_ts));
        bus_read(ADDR_RXSTAT, d);
        if (d !== 32'(exp_rs)) report_mismatch("rxstat", d, 32'(exp_rs));
        bus_read(ADDR_RXDATA, d);
        if (d !== 32'd0) report_mismatch("rxdata", d, 32'd0);
        finish_test("reset_state", err0);
    endtask

    task automatic frame_format();
        int         err0;
        int         p;
        logic [7:0] b;
        logic [7:0] seen;
        time        t0;
        err0 = errors;
        for (p = 0; p < 4; p++) begin          // all four parity codes, one stop bit
            b = 8'($urandom);
            fork
                send_byte(b, 2'(p), 1'b0);
                monitor_frame(2'(p), 1'b0, seen, t0);
            join
            if (seen !== b) report_mismatch("tx data bits", 32'(seen), 32'(b));
            exp_q.delete();
            exp_q.push_back(b);
            collect_frames(1);
            check_frames();
        end
        finish_test("frame_format", err0);
    endtask

    task automatic back_to_back();
        int         err0;
        int         i;
        int         j;
        logic [7:0] seen;
        time        t0;
        time        gap;
        logic [7:0] seen_q[$];
        time        t_q[$];
        err0 = errors;
        exp_q.delete();
        for (i = 0; i < 3; i++) exp_q.push_back(8'($urandom));
        fork
            begin
                for (j = 0; j < 3; j++) send_byte(exp_q[j], PAR_NONE, 1'b1);
            end
            begin
                repeat (3) begin
                    monitor_frame(PAR_NONE, 1'b1, seen, t0);
                    seen_q.push_back(seen);
                    t_q.push_back(t0);
                end
            end
        join
        for (i = 0; i < 3; i++)
            if (seen_q[i] !== exp_q[i]) report_mismatch("tx data bits", 32'(seen_q[i]),
                                                        32'(exp_q[i]));
        // start, 8 data, 2 stop: next start edge right after the second stop bit
        for (i = 1; i < 3; i++) begin
            gap = t_q[i] - t_q[i-1];
            if (gap != 64'(11 * BIT_NS)) report_mismatch("tx frame spacing ns", 32'(gap),
                                                         32'(11 * BIT_NS));
        end
        collect_frames(3);
        check_frames();
        finish_test("back_to_back", err0);
    endtask

    task automatic overflow();
        int          err0;
        int          i;
        logic [7:0]  b;
        logic [31:0] d;
        tx_status_t  ts;
        rx_status_t  rs;
        logic        full_seen;
        err0      = errors;
        full_seen = 1'b0;
        exp_q.delete();
        // four cycles per push, far faster than one 80-cycle frame
        for (i = 0; i < 18; i++) begin
            b = 8'($urandom);
            bus_write(ADDR_DIN, {24'd0, b});
            bus_read(ADDR_TXSTAT, d);
            ts = tx_status_t'(d[7:0]);
            if (ts.buffer_count > 5'd16)
                report_mismatch("tx buffer_count", 32'(ts.buffer_count), 32'd16);
            if (ts.txbf) full_seen = 1'b1;     // this push will be lost
            else exp_q.push_back(b);
            bus_write(ADDR_CON, con_word(PAR_NONE, 1'b0, 1'b1));
            bus_write(ADDR_CON, con_word(PAR_NONE, 1'b0, 1'b0));
        end
        if (!full_seen) report_problem("tx buffer never reported full");
        if (exp_q.size() < 16 || exp_q.size() > 17)
            report_problem($sformatf("%0d pushes accepted, expected 16 or 17", exp_q.size()));
        collect_frames(exp_q.size());
        check_frames();
        repeat (3 * 10 * BIT_CYC) @(negedge clk);
        bus_read(ADDR_RXSTAT, d);
        rs = rx_status_t'(d[6:0]);
        if (!rs.rx_empty) report_problem("frame received after the accepted sequence");
        finish_test("overflow", err0);
    endtask

    task automatic error_flags();
        int         err0;
        logic [7:0] b;
        rx_frame_t  exp_f;
        err0     = errors;
        loopback = 1'b0;
        bus_write(ADDR_CON, con_word(PAR_EVEN, 1'b0, 1'b0));
        b = 8'($urandom);
        drive_frame(b, PAR_EVEN, 1'b1, 1'b0);        // wrong parity bit
        collect_frames(1);
        exp_f = '{frame_err: 1'b0, parity_err: 1'b1, data: b};
        if (got_q.size() != 1) report_problem("no frame after a bad parity bit");
        else if (got_q[0] !== exp_f) report_mismatch("rxdata", 32'(got_q[0]), 32'(exp_f));
        b = 8'($urandom);
        drive_frame(b, PAR_EVEN, 1'b0, 1'b1);        // stop bit low
        collect_frames(1);
        exp_f = '{frame_err: 1'b1, parity_err: 1'b0, data: b};
        if (got_q.size() != 1) report_problem("no frame after a low stop bit");
        else if (got_q[0] !== exp_f) report_mismatch("rxdata", 32'(got_q[0]), 32'(exp_f));
        loopback = 1'b1;
        finish_test("error_flags", err0);
    endtask

    task automatic random_configs();
        int         err0;
        int         i;
        logic [7:0] b;
        logic [1:0] par;
        logic       st;
        err0 = errors;
        for (i = 0; i < 10; i++) begin
            b   = 8'($urandom);
            par = 2'($urandom);
            st  = 1'($urandom);
            exp_q.delete();
            exp_q.push_back(b);
            send_byte(b, par, st);
            collect_frames(1);
            check_frames();
            repeat (2 * BIT_CYC) @(negedge clk);    // encoder back to idle before cfg moves
        end
        finish_test("random_configs", err0);
    endtask

    initial begin
        nrst         = 1'b0;
        wr           = 1'b0;
        rd           = 1'b0;
        addr         = ADDR_CON;
        wdata        = 32'd0;
        drv_rx       = 1'b1;
        loopback     = 1'b1;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        void'($urandom(32'hfca9));
        repeat (16) @(negedge clk);
        nrst = 1'b1;
        @(negedge clk);
        reset_state();
        bus_write(ADDR_BAUD, 32'(BIT_CYC - 1));
        frame_format();
        back_to_back();
        overflow();
        error_flags();
        random_configs();
        $display("summary: %0d tests run, %0d failed, %0d errors",
                 tests_run, tests_failed, errors);
        if (errors == 0) $display("RESULT: PASS");
        else $display("RESULT: FAIL");
        $finish;
    end

endmodule

// ==== project.f ====
src/uart_pkg.sv
src/uart_fifo.sv
src/uart_encoder.sv
src/uart_decoder.sv
src/uart_regs.sv
src/uart_top.sv
bench/uart_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/10ps
TOP       = uart_tb
FILELIST  = project.f
OBJ_DIR   = obj_dir
LOG       = sim.log
SOURCES   = $(wildcard src/*.sv bench/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
